// ==== hw/ia_pkg.sv ====
// activation loader shared types
package ia_pkg;

    // ========================================
    // widths and bus constants
    // ========================================
    localparam int reg_width      = 32;  // sizes, addresses, strides
    localparam int bus_width      = 32;  // read data bus
    localparam int bytes_per_beat = 4;
    localparam int len_width      = 4;   // burst length field, beats minus one
    localparam int elem_width     = 16;  // unpacked element, s8 gets sign extended
    localparam int lanes_per_beat = 4;   // max elements per beat (s8 mode)

    // ========================================
    // configuration and derived geometry
    // ========================================
    typedef struct packed {
        logic [reg_width-1:0] k;          // activation rows
        logic [reg_width-1:0] n;          // activation cols
        logic [reg_width-1:0] m;          // output cols, sets the loop count
        logic [reg_width-1:0] base;       // byte address of element (0,0)
        logic [reg_width-1:0] stride;     // bytes between matrix rows
        logic                 use_16bits; // 1 = s16, 0 = s8
    } ia_cfg_t;

    typedef struct packed {
        logic [reg_width-1:0] row_tiles;  // ceil(n/SIZE), tiles across a row
        logic [reg_width-1:0] col_tiles;  // ceil(k/SIZE), tile rows
        logic [reg_width-1:0] loop_num;   // ceil(m/SIZE), repeats per tile row
        logic [reg_width-1:0] last_rows;  // valid rows in the bottom tile row
        logic [reg_width-1:0] full_beats; // beats per row, normal tile
        logic [reg_width-1:0] last_beats; // beats per row, rightmost tile
    } ia_geom_t;

endpackage

// ==== hw/ia_job_if.sv ====
// tile fetch job channel
interface ia_job_if import ia_pkg::*; #(
    parameter int SIZE = 4
) ();

    logic                   job_valid;
    logic                   job_ready;
    logic [reg_width-1:0]   addr;       // first byte of tile row 0
    logic [reg_width-1:0]   stride;
    logic [$clog2(SIZE):0]  rows;       // valid rows, 1..SIZE
    logic [len_width-1:0]   beats;      // beats per row
    logic                   use_16bits;

    modport walker (
        output job_valid, addr, stride, rows, beats, use_16bits,
        input  job_ready
    );

    modport fetch (
        input  job_valid, addr, stride, rows, beats, use_16bits,
        output job_ready
    );

endinterface

// ==== hw/ia_fill_if.sv ====
// tile buffer fill channel
interface ia_fill_if import ia_pkg::*; #(
    parameter int SIZE = 4
) ();

    logic [lanes_per_beat-1:0]     wr_en;     // per lane write strobe
    logic [$clog2(SIZE)-1:0]       wr_row;
    logic [$clog2(SIZE)-1:0]       wr_col;    // column of lane 0
    logic signed [elem_width-1:0]  wr_lanes [lanes_per_beat];
    logic                          tile_done; // last beat of the tile
    logic [$clog2(SIZE):0]         rows;      // valid rows of the buffered tile
    logic                          buf_free;  // no unsent tile held

    modport fetch (
        output wr_en, wr_row, wr_col, wr_lanes, tile_done, rows,
        input  buf_free
    );

    modport sender (
        input  wr_en, wr_row, wr_col, wr_lanes, tile_done, rows,
        output buf_free
    );

endinterface

// ==== hw/ia_tile_walker.sv ====
// tile order walker
module ia_tile_walker import ia_pkg::*; #(
    parameter int SIZE = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 init_cfg,
    input  logic [reg_width-1:0] k,
    input  logic [reg_width-1:0] n,
    input  logic [reg_width-1:0] m,
    input  logic [reg_width-1:0] base,
    input  logic [reg_width-1:0] stride,
    input  logic                 use_16bits,
    output logic                 load_ia_req,
    input  logic                 load_ia_granted,
    input  logic                 sending_done,
    ia_job_if.walker             job,
    output logic                 first_col,
    output logic                 last_col
);

    localparam int lg     = $clog2(SIZE);
    localparam int rows_w = lg + 1;

    typedef enum logic [1:0] {st_idle, st_geom, st_req, st_busy} state_t;

    state_t               state;
    ia_cfg_t              cfg;
    ia_geom_t             geom;
    logic [reg_width-1:0] tile_row_idx;
    logic [reg_width-1:0] tile_col_idx;
    logic [reg_width-1:0] loop_cnt;
    logic [reg_width-1:0] row_base;   // address of current tile row
    logic [reg_width-1:0] tile_addr;  // address of current tile
    logic [reg_width-1:0] last_cols;
    logic [reg_width-1:0] row_step;
    logic                 last_loop;
    logic                 last_row;

    // valid columns in the rightmost tile, low bits of n or a full tile
    assign last_cols = (cfg.n[lg-1:0] == '0) ? reg_width'(SIZE) : reg_width'(cfg.n[lg-1:0]);
    assign row_step  = cfg.stride << lg;  // SIZE matrix rows down

    assign first_col = (tile_col_idx == '0);
    assign last_col  = (tile_col_idx == geom.row_tiles - 1'b1);
    assign last_loop = (loop_cnt == geom.loop_num - 1'b1);
    assign last_row  = (tile_row_idx == geom.col_tiles - 1'b1);

    // job fields follow the indices, stable while a tile is in flight
    assign job.addr       = tile_addr;
    assign job.stride     = cfg.stride;
    assign job.use_16bits = cfg.use_16bits;
    assign job.rows       = last_row ? rows_w'(geom.last_rows) : rows_w'(SIZE);
    assign job.beats      = last_col ? len_width'(geom.last_beats) : len_width'(geom.full_beats);

    // ========================================
    // config latch and geometry
    // ========================================
    always_ff @(posedge clk) begin
        if (state == st_idle && init_cfg) begin
            cfg <= '{k: k, n: n, m: m, base: base, stride: stride, use_16bits: use_16bits};
        end
        if (state == st_geom) begin
            // ceil division as add then shift
            geom.row_tiles  <= (cfg.n + reg_width'(SIZE - 1)) >> lg;
            geom.col_tiles  <= (cfg.k + reg_width'(SIZE - 1)) >> lg;
            geom.loop_num   <= (cfg.m + reg_width'(SIZE - 1)) >> lg;
            geom.last_rows  <= (cfg.k[lg-1:0] == '0) ? reg_width'(SIZE)
                                                     : reg_width'(cfg.k[lg-1:0]);
            geom.full_beats <= (reg_width'(SIZE) << cfg.use_16bits) >> $clog2(bytes_per_beat);
            geom.last_beats <= ((last_cols << cfg.use_16bits) + reg_width'(bytes_per_beat - 1))
                               >> $clog2(bytes_per_beat);
        end
    end

    // ========================================
    // loader FSM and tile indices
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= st_idle;
            load_ia_req   <= 1'b0;
            job.job_valid <= 1'b0;
            tile_row_idx  <= '0;
            tile_col_idx  <= '0;
            loop_cnt      <= '0;
            row_base      <= '0;
            tile_addr     <= '0;
        end else begin
            if (job.job_valid && job.job_ready)
                job.job_valid <= 1'b0;
            case (state)
                st_idle: if (init_cfg) state <= st_geom;
                st_geom: begin  // cfg valid, start at tile (0,0)
                    tile_row_idx <= '0;
                    tile_col_idx <= '0;
                    loop_cnt     <= '0;
                    row_base     <= cfg.base;
                    tile_addr    <= cfg.base;
                    state        <= st_req;
                end
                st_req: begin
                    if (!load_ia_req) begin
                        load_ia_req <= 1'b1;
                    end else if (load_ia_granted) begin  // grant only counts while asking
                        load_ia_req   <= 1'b0;
                        job.job_valid <= 1'b1;
                        state         <= st_busy;
                    end
                end
                st_busy: begin
                    if (sending_done) begin
                        if (!last_col) begin  // next tile across
                            tile_col_idx <= tile_col_idx + 1'b1;
                            tile_addr    <= tile_addr + (reg_width'(SIZE) << cfg.use_16bits);
                        end else if (!last_loop) begin  // replay the tile row
                            tile_col_idx <= '0;
                            loop_cnt     <= loop_cnt + 1'b1;
                            tile_addr    <= row_base;
                        end else begin  // move down a tile row
                            tile_col_idx <= '0;
                            loop_cnt     <= '0;
                            tile_row_idx <= tile_row_idx + 1'b1;
                            row_base     <= row_base + row_step;
                            tile_addr    <= row_base + row_step;
                        end
                        state <= (last_col && last_loop && last_row) ? st_idle : st_req;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// ==== hw/ia_tile_fetch.sv ====
// tile burst fetch and unpack
module ia_tile_fetch import ia_pkg::*; #(
    parameter int SIZE = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    ia_job_if.fetch              job,
    ia_fill_if.fetch             fill,
    output logic                 bus_cmd_valid,
    input  logic                 bus_cmd_ready,
    output logic [reg_width-1:0] bus_cmd_addr,
    output logic [len_width-1:0] bus_cmd_len,
    input  logic                 bus_rsp_valid,
    output logic                 bus_rsp_ready,
    input  logic [bus_width-1:0] bus_rsp_rdata
);

    localparam int lg   = $clog2(SIZE);
    localparam int half = lanes_per_beat / 2;  // s16 lanes per beat

    logic                 active;
    logic                 job_hs;
    logic                 cmd_hs;
    logic                 rsp_hs;
    logic [reg_width-1:0] stride_r;
    logic [lg:0]          rows_r;
    logic [len_width-1:0] beats_r;
    logic                 use16_r;
    logic [lg-1:0]        cmd_row;   // command side row
    logic [lg-1:0]        rsp_row;   // response side row
    logic [len_width-1:0] beat_cnt;
    logic [len_width+1:0] col;       // beat_cnt times lanes
    logic                 last_beat;
    logic                 last_row;

    assign job.job_ready = fill.buf_free && !active;
    assign job_hs    = job.job_valid && job.job_ready;
    assign cmd_hs    = bus_cmd_valid && bus_cmd_ready;
    assign rsp_hs    = bus_rsp_valid && bus_rsp_ready;
    assign last_beat = (beat_cnt == beats_r - 1'b1);
    assign last_row  = ({1'b0, rsp_row} == rows_r - 1'b1);
    assign bus_cmd_len = beats_r - 1'b1;

    // ========================================
    // beat unpack
    // ========================================
    assign col = (len_width + 2)'(beat_cnt) << (use16_r ? 1 : 2);

    always_comb begin
        for (int i = 0; i < lanes_per_beat; i++) begin
            if (use16_r)
                fill.wr_lanes[i] = $signed(bus_rsp_rdata[16*(i%half) +: 16]);
            else
                fill.wr_lanes[i] = elem_width'($signed(bus_rsp_rdata[8*i +: 8]));  // sign ext
            // upper lanes idle in s16 mode, nothing past SIZE
            fill.wr_en[i] = rsp_hs && (!use16_r || i < half) && (col + i < SIZE);
        end
    end

    assign fill.wr_row    = rsp_row;
    assign fill.wr_col    = col[lg-1:0];
    assign fill.rows      = rows_r;
    assign fill.tile_done = rsp_hs && last_beat && last_row;

    // job payload and command address
    always_ff @(posedge clk) begin
        if (job_hs) begin
            stride_r     <= job.stride;
            rows_r       <= job.rows;
            beats_r      <= job.beats;
            use16_r      <= job.use_16bits;
            bus_cmd_addr <= job.addr;
        end else if (cmd_hs) begin
            bus_cmd_addr <= bus_cmd_addr + stride_r;  // next matrix row
        end
    end

    // ========================================
    // command and response counters
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active        <= 1'b0;
            bus_cmd_valid <= 1'b0;
            bus_rsp_ready <= 1'b0;
            cmd_row       <= '0;
            rsp_row       <= '0;
            beat_cnt      <= '0;
        end else if (job_hs) begin
            active        <= 1'b1;
            bus_cmd_valid <= 1'b1;  // row 0 goes out next cycle
            bus_rsp_ready <= 1'b1;
            cmd_row       <= '0;
            rsp_row       <= '0;
            beat_cnt      <= '0;
        end else begin
            if (cmd_hs) begin
                if ({1'b0, cmd_row} == rows_r - 1'b1)
                    bus_cmd_valid <= 1'b0;  // all rows issued
                else
                    cmd_row <= cmd_row + 1'b1;
            end
            if (rsp_hs) begin
                if (last_beat) begin
                    beat_cnt <= '0;
                    if (last_row) begin
                        active        <= 1'b0;
                        bus_rsp_ready <= 1'b0;
                    end else begin
                        rsp_row <= rsp_row + 1'b1;
                    end
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== hw/ia_row_sender.sv ====
// tile buffer and row sender
module ia_row_sender import ia_pkg::*; #(
    parameter int SIZE       = 4,
    parameter int DATA_WIDTH = elem_width
) (
    input  logic                         clk,
    input  logic                         rst_n,
    ia_fill_if.sender                    fill,
    input  logic                         send_ia_trigger,
    input  logic                         first_col,
    input  logic                         last_col,
    output logic signed [DATA_WIDTH-1:0] ia_out [SIZE],
    output logic                         ia_row_valid,
    output logic                         ia_is_init_data,
    output logic                         ia_calc_done,
    output logic                         ia_data_valid,
    output logic                         sending_done
);

    localparam int lg = $clog2(SIZE);

    logic signed [DATA_WIDTH-1:0] tile_buf [SIZE][SIZE];
    logic                         sending;
    logic [lg-1:0]                row_idx;  // row on ia_out
    logic                         trig_ok;

    assign trig_ok       = send_ia_trigger && ia_data_valid;  // stray triggers dropped
    assign fill.buf_free = !ia_data_valid && !sending;

    // lane writes from the fetch stage
    always_ff @(posedge clk) begin
        for (int i = 0; i < lanes_per_beat; i++) begin
            if (fill.wr_en[i])
                tile_buf[fill.wr_row][fill.wr_col + lg'(i)] <= DATA_WIDTH'(fill.wr_lanes[i]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ia_data_valid <= 1'b0;
            sending       <= 1'b0;
            sending_done  <= 1'b0;
            row_idx       <= '0;
        end else begin
            sending_done <= 1'b0;
            if (fill.tile_done)
                ia_data_valid <= 1'b1;
            else if (trig_ok)
                ia_data_valid <= 1'b0;
            if (trig_ok) begin
                sending <= 1'b1;
                row_idx <= '0;
            end else if (sending) begin
                if ({1'b0, row_idx} == fill.rows - 1'b1) begin  // last valid row out
                    sending      <= 1'b0;
                    sending_done <= 1'b1;
                end else begin
                    row_idx <= row_idx + 1'b1;
                end
            end
        end
    end

    // row flags follow the walker's tile column
    assign ia_row_valid    = sending;
    assign ia_is_init_data = sending && first_col;
    assign ia_calc_done    = sending && last_col;

    always_comb begin
        for (int c = 0; c < SIZE; c++)
            ia_out[c] = tile_buf[row_idx][c];  // cols past n left stale
    end

endmodule

// ==== hw/ia_loader_top.sv ====
// activation loader top
module ia_loader_top import ia_pkg::*; #(
    parameter int SIZE       = 4,
    parameter int DATA_WIDTH = elem_width
) (
    input  logic                         clk,
    input  logic                         rst_n,
    // configuration
    input  logic                         init_cfg,
    input  logic [reg_width-1:0]         k,
    input  logic [reg_width-1:0]         n,
    input  logic [reg_width-1:0]         m,
    input  logic [reg_width-1:0]         base,
    input  logic [reg_width-1:0]         stride,
    input  logic                         use_16bits,
    // scheduler
    output logic                         load_ia_req,
    input  logic                         load_ia_granted,
    input  logic                         send_ia_trigger,
    // read bus
    output logic                         bus_cmd_valid,
    input  logic                         bus_cmd_ready,
    output logic [reg_width-1:0]         bus_cmd_addr,
    output logic [len_width-1:0]         bus_cmd_len,
    input  logic                         bus_rsp_valid,
    output logic                         bus_rsp_ready,
    input  logic [bus_width-1:0]         bus_rsp_rdata,
    // systolic array
    output logic signed [DATA_WIDTH-1:0] ia_out [SIZE],
    output logic                         ia_row_valid,
    output logic                         ia_is_init_data,
    output logic                         ia_calc_done,
    output logic                         ia_data_valid,
    output logic                         ia_sending_done
);

    logic first_col;
    logic last_col;

    ia_job_if  #(.SIZE(SIZE)) job ();
    ia_fill_if #(.SIZE(SIZE)) fill ();

    ia_tile_walker #(.SIZE(SIZE)) ia_tile_walker_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .init_cfg        (init_cfg),
        .k               (k),
        .n               (n),
        .m               (m),
        .base            (base),
        .stride          (stride),
        .use_16bits      (use_16bits),
        .load_ia_req     (load_ia_req),
        .load_ia_granted (load_ia_granted),
        .sending_done    (ia_sending_done),
        .job             (job.walker),
        .first_col       (first_col),
        .last_col        (last_col)
    );

    ia_tile_fetch #(.SIZE(SIZE)) ia_tile_fetch_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .job           (job.fetch),
        .fill          (fill.fetch),
        .bus_cmd_valid (bus_cmd_valid),
        .bus_cmd_ready (bus_cmd_ready),
        .bus_cmd_addr  (bus_cmd_addr),
        .bus_cmd_len   (bus_cmd_len),
        .bus_rsp_valid (bus_rsp_valid),
        .bus_rsp_ready (bus_rsp_ready),
        .bus_rsp_rdata (bus_rsp_rdata)
    );

    ia_row_sender #(.SIZE(SIZE), .DATA_WIDTH(DATA_WIDTH)) ia_row_sender_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .fill            (fill.sender),
        .send_ia_trigger (send_ia_trigger),
        .first_col       (first_col),
        .last_col        (last_col),
        .ia_out          (ia_out),
        .ia_row_valid    (ia_row_valid),
        .ia_is_init_data (ia_is_init_data),
        .ia_calc_done    (ia_calc_done),
        .ia_data_valid   (ia_data_valid),
        .sending_done    (ia_sending_done)
    );

endmodule

// ==== tb/ia_mem_model.sv ====
// burst read memory model
module ia_mem_model import ia_pkg::*; #(
    parameter int MEM_BYTES = 4096
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 bus_cmd_valid,
    output logic                 bus_cmd_ready,
    input  logic [reg_width-1:0] bus_cmd_addr,
    input  logic [len_width-1:0] bus_cmd_len,
    output logic                 bus_rsp_valid,
    input  logic                 bus_rsp_ready,
    output logic [bus_width-1:0] bus_rsp_rdata
);

    logic [7:0]           mem [MEM_BYTES];
    int                   seed = 32'h82f9_b648;
    logic [reg_width-1:0] addr_q [$];  // command log, oldest first
    logic [len_width-1:0] len_q [$];
    int                   beat;        // beat within the oldest burst

    // lowest address lands in the low byte
    function automatic logic [bus_width-1:0] word_at(logic [reg_width-1:0] a);
        return {mem[a + 3], mem[a + 2], mem[a + 1], mem[a]};
    endfunction

    initial begin
        for (int i = 0; i < MEM_BYTES; i++)
            mem[i] = 8'($random(seed));
        bus_cmd_ready = 1'b0;
        bus_rsp_valid = 1'b0;
        bus_rsp_rdata = '0;
        beat          = 0;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus_cmd_ready <= 1'b0;
            bus_rsp_valid <= 1'b0;
        end else begin
            if (bus_cmd_valid && bus_cmd_ready) begin
                addr_q.push_back(bus_cmd_addr);
                len_q.push_back(bus_cmd_len);
            end
            if (bus_rsp_valid && bus_rsp_ready) begin
                if (beat == int'(len_q[0])) begin  // burst complete
                    void'(addr_q.pop_front());
                    void'(len_q.pop_front());
                    beat = 0;
                end else begin
                    beat = beat + 1;
                end
            end
            bus_cmd_ready <= ($random(seed) & 3) != 0;  // stall about one cycle in four
            if (!bus_rsp_valid || bus_rsp_ready) begin  // else hold the offered beat
                if (addr_q.size() > 0 && ($random(seed) & 3) != 0) begin
                    bus_rsp_valid <= 1'b1;
                    bus_rsp_rdata <= word_at(addr_q[0] + reg_width'(bytes_per_beat * beat));
                end else begin
                    bus_rsp_valid <= 1'b0;  // random gap
                end
            end
        end
    end

endmodule

// ==== tb/ia_loader_tb.sv ====
// activation loader testbench
module ia_loader_tb import ia_pkg::*; ();

    localparam int SIZE      = 4;
    localparam int num_cases = 4;

    logic                         clk = 1'b0;
    logic                         rst_n;
    logic                         init_cfg;
    logic [reg_width-1:0]         k, n, m, base, stride;
    logic                         use_16bits;
    logic                         load_ia_req;
    logic                         load_ia_granted;
    logic                         send_ia_trigger;
    logic                         bus_cmd_valid, bus_cmd_ready;
    logic [reg_width-1:0]         bus_cmd_addr;
    logic [len_width-1:0]         bus_cmd_len;
    logic                         bus_rsp_valid, bus_rsp_ready;
    logic [bus_width-1:0]         bus_rsp_rdata;
    logic signed [elem_width-1:0] ia_out [SIZE];
    logic                         ia_row_valid, ia_is_init_data, ia_calc_done;
    logic                         ia_data_valid, ia_sending_done;

    // ========================================
    // case table
    // ========================================
    typedef struct {
        string name;
        int    k;
        int    n;
        int    m;
        bit    use16;
        int    base;
        int    stride;    // bytes between matrix rows
        int    trig_dly;  // cycles from ia_data_valid to trigger
    } case_t;

    case_t cases [num_cases];
    int    cur_case, cur_tr, cur_tc;        // tile the scheduler is serving
    int    row_cnt, cmd_cnt, rsp_cnt, tiles_done, req_rises;
    int    mon_errs, seq_errs, cycles, limit;
    bit    trig_prev, row_prev, done_prev, req_prev, dv_exp;

    ia_loader_top #(.SIZE(SIZE), .DATA_WIDTH(elem_width)) ia_loader_top_inst (.*);
    ia_mem_model ia_mem_model_inst (.*);

    always #2 clk = ~clk;

    // ========================================
    // reference model
    // ========================================
    function automatic int ceil_tiles(int x);
        return (x + SIZE - 1) / SIZE;
    endfunction

    function automatic int valid_rows(int ci, int tr);
        return (cases[ci].k - tr * SIZE < SIZE) ? cases[ci].k - tr * SIZE : SIZE;
    endfunction

    function automatic int valid_cols(int ci, int tc);
        return (cases[ci].n - tc * SIZE < SIZE) ? cases[ci].n - tc * SIZE : SIZE;
    endfunction

    function automatic int tile_beats(int ci, int tc);
        return (valid_cols(ci, tc) * (cases[ci].use16 ? 2 : 1) + bytes_per_beat - 1)
               / bytes_per_beat;
    endfunction

    // byte address of element (r,c) inside tile (tr,tc)
    function automatic int elem_addr(int ci, int tr, int tc, int r, int c);
        return cases[ci].base + (tr * SIZE + r) * cases[ci].stride
               + (tc * SIZE + c) * (cases[ci].use16 ? 2 : 1);
    endfunction

    function automatic int ref_elem(int ci, int tr, int tc, int r, int c);
        int a;
        a = elem_addr(ci, tr, tc, r, c);
        if (cases[ci].use16)  // little endian halfword
            return int'($signed({ia_mem_model_inst.mem[a + 1], ia_mem_model_inst.mem[a]}));
        return int'($signed(ia_mem_model_inst.mem[a]));
    endfunction

    function automatic int case_beats(int ci);
        int total;
        total = 0;
        for (int tr = 0; tr < ceil_tiles(cases[ci].k); tr++)
            for (int tc = 0; tc < ceil_tiles(cases[ci].n); tc++)
                total += valid_rows(ci, tr) * tile_beats(ci, tc);
        return total * ceil_tiles(cases[ci].m);  // every tile row replayed loop_num times
    endfunction

    task automatic check_val(string what, int exp, int act);
        assert (exp == act) else begin
            mon_errs++;
            $display("Fail %s %s: expected %0d, actual %0d", cases[cur_case].name, what, exp, act);
        end
    endtask

    // ========================================
    // bus and row monitor
    // ========================================
    always @(posedge clk) begin
        if (rst_n) begin
            if (bus_cmd_valid && bus_cmd_ready) begin
                check_val("cmd addr", elem_addr(cur_case, cur_tr, cur_tc, cmd_cnt, 0),
                          int'(bus_cmd_addr));
                check_val("cmd len", tile_beats(cur_case, cur_tc) - 1, int'(bus_cmd_len));
                cmd_cnt++;
            end
            // data valid follows the last beat, clears on the trigger
            check_val("data valid", dv_exp, ia_data_valid);
            if (dv_exp || ia_row_valid)
                check_val("rsp ready", 0, bus_rsp_ready);  // fetch idle once tile is in
            if (send_ia_trigger && dv_exp)
                dv_exp = 1'b0;
            if (bus_rsp_valid && bus_rsp_ready) begin
                rsp_cnt++;
                if (rsp_cnt == valid_rows(cur_case, cur_tr) * tile_beats(cur_case, cur_tc))
                    dv_exp = 1'b1;  // last beat of the tile
            end
            if (trig_prev) begin  // first row one cycle after an accepted trigger
                assert (ia_row_valid && row_cnt == 0) else begin
                    mon_errs++;
                    $display("%s: first row did not follow the trigger", cases[cur_case].name);
                end
            end
            if (ia_row_valid) begin
                for (int c = 0; c < valid_cols(cur_case, cur_tc); c++)
                    check_val($sformatf("row %0d col %0d", row_cnt, c),
                              ref_elem(cur_case, cur_tr, cur_tc, row_cnt, c), int'(ia_out[c]));
                check_val("init flag", cur_tc == 0, ia_is_init_data);
                check_val("calc done flag", cur_tc == ceil_tiles(cases[cur_case].n) - 1,
                          ia_calc_done);
                row_cnt++;
            end
            if (ia_sending_done) begin
                check_val("rows sent", valid_rows(cur_case, cur_tr), row_cnt);
                check_val("commands", valid_rows(cur_case, cur_tr), cmd_cnt);
                check_val("beats", valid_rows(cur_case, cur_tr) * tile_beats(cur_case, cur_tc),
                          rsp_cnt);
                assert (row_prev && !done_prev) else begin
                    mon_errs++;
                    $display("%s: sending done was not one pulse after the last row",
                             cases[cur_case].name);
                end
                row_cnt = 0;
                cmd_cnt = 0;
                rsp_cnt = 0;
                tiles_done++;
            end else begin
                assert (!(row_prev && !ia_row_valid)) else begin
                    mon_errs++;
                    $display("%s: rows stopped without sending done", cases[cur_case].name);
                end
            end
            if (load_ia_req && !req_prev)
                req_rises++;
            trig_prev = send_ia_trigger && ia_data_valid;
            row_prev  = ia_row_valid;
            done_prev = ia_sending_done;
            req_prev  = load_ia_req;
        end
    end

    // ========================================
    // scheduler
    // ========================================
    task automatic serve_tile(int tr, int tc);
        cur_tr = tr;
        cur_tc = tc;
        while (!load_ia_req)
            @(posedge clk);
        repeat (2) @(posedge clk);  // grant latency
        load_ia_granted <= 1'b1;
        @(posedge clk);
        load_ia_granted <= 1'b0;
        @(posedge clk);
        assert (!load_ia_req) else begin
            seq_errs++;
            $display("%s: load_ia_req still high after the grant", cases[cur_case].name);
        end
        while (!ia_data_valid)
            @(posedge clk);
        repeat (cases[cur_case].trig_dly) @(posedge clk);
        send_ia_trigger <= 1'b1;
        @(posedge clk);
        send_ia_trigger <= 1'b0;
        while (!ia_sending_done)
            @(posedge clk);
        @(posedge clk);
    endtask

    task automatic run_case(int ci);
        int tiles0;
        int rises0;
        int exp_tiles;
        cur_case   = ci;
        tiles0     = tiles_done;
        rises0     = req_rises;
        exp_tiles  = ceil_tiles(cases[ci].k) * ceil_tiles(cases[ci].m) * ceil_tiles(cases[ci].n);
        init_cfg   <= 1'b1;
        k          <= cases[ci].k;
        n          <= cases[ci].n;
        m          <= cases[ci].m;
        base       <= cases[ci].base;
        stride     <= cases[ci].stride;
        use_16bits <= cases[ci].use16;
        @(posedge clk);
        init_cfg <= 1'b0;
        for (int tr = 0; tr < ceil_tiles(cases[ci].k); tr++)      // tile row
            for (int lp = 0; lp < ceil_tiles(cases[ci].m); lp++)  // loop
                for (int tc = 0; tc < ceil_tiles(cases[ci].n); tc++)
                    serve_tile(tr, tc);
        repeat (20) begin  // loader must sit idle now
            @(posedge clk);
            assert (!load_ia_req) else begin
                seq_errs++;
                $display("%s: request raised after the final tile", cases[ci].name);
            end
        end
        assert (tiles_done - tiles0 == exp_tiles) else begin
            seq_errs++;
            $display("Fail %s tiles: expected %0d, actual %0d", cases[ci].name, exp_tiles,
                     tiles_done - tiles0);
        end
        assert (req_rises - rises0 == exp_tiles) else begin
            seq_errs++;
            $display("Fail %s requests: expected %0d, actual %0d", cases[ci].name, exp_tiles,
                     req_rises - rises0);
        end
    endtask

    initial begin
        cases[0] = '{"s8_edge",   6, 10, 5, 1'b0, 'h100, 16, 2};
        cases[1] = '{"s16_edge",  5,  6, 8, 1'b1, 'h400, 16, 0};
        cases[2] = '{"s16_full",  8,  8, 4, 1'b1, 'h800, 20, 3};
        cases[3] = '{"s8_single", 3,  3, 1, 1'b0, 'hc00,  4, 1};
        rst_n           = 1'b0;
        init_cfg        = 1'b0;
        k               = '0;
        n               = '0;
        m               = '0;
        base            = '0;
        stride          = '0;
        use_16bits      = 1'b0;
        load_ia_granted = 1'b0;
        send_ia_trigger = 1'b0;
        limit           = 200;
        for (int i = 0; i < num_cases; i++)
            limit += 40 * case_beats(i);
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < num_cases; i++)
            run_case(i);
        $display("errors: monitor %0d, sequence %0d", mon_errs, seq_errs);
        if (mon_errs + seq_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // run length guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

endmodule

// ==== sources.f ====
hw/ia_pkg.sv
hw/ia_job_if.sv
hw/ia_fill_if.sv
hw/ia_tile_walker.sv
hw/ia_tile_fetch.sv
hw/ia_row_sender.sv
hw/ia_loader_top.sv
tb/ia_mem_model.sv
tb/ia_loader_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= ia_loader_tb
RTL_TOP    ?= ia_loader_top
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only -Wall
PASS_MSG   ?= Done: no errors
RTL_SRCS   ?= hw/ia_pkg.sv hw/ia_job_if.sv hw/ia_fill_if.sv hw/ia_tile_walker.sv \
              hw/ia_tile_fetch.sv hw/ia_row_sender.sv hw/ia_loader_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
